/* Bender.yml */
package:
  name: fetch_predictor

sources:
  # package first, then the blocks, then the top level.
  - verilog/bp_pkg.sv
  - verilog/local_history_predictor.sv
  - verilog/branch_target_buffer.sv
  - verilog/next_pc_select.sv
  - verilog/fetch_predictor.sv

  # testbench and bound assertions.
  - target: test
    files:
      - test/fetch_predictor_sva.sv
      - test/fetch_predictor_tb.sv

/* test/fetch_predictor_sva.sv */
module fetch_predictor_sva (
    input logic                      clk,
    input logic                      rst,
    input logic [bp_pkg::addr_w-1:0] pc,
    input bp_pkg::bp_pred_t          pred
);
    timeunit 1ns;
    timeprecision 1ps;

    import bp_pkg::*;

    int fail_count = 0;                                   // number of failed assertions.

    // ----------------------------------------------------------------------
    // prediction properties
    // ----------------------------------------------------------------------

    // Without a redirect the fetch goes on sequentially.
    seq_when_not_taken: assert property (
        @(posedge clk) disable iff (rst)
        !pred.taken |-> pred.next_pc == pc + addr_w'(4)
    ) else begin
        fail_count = fail_count + 1;
        $error("next_pc is not pc plus 4 while the prediction is not taken");
    end

    taken_needs_hit: assert property (
        @(posedge clk) disable iff (rst)
        pred.taken |-> pred.hit                           // a redirect needs a buffer target.
    ) else begin
        fail_count = fail_count + 1;
        $error("prediction is taken without a buffer hit");
    end

    // ----------------------------------------------------------------------
    // reset
    // ----------------------------------------------------------------------

    hit_low_after_reset: assert property (
        @(posedge clk) rst |=> !pred.hit
    ) else begin
        fail_count = fail_count + 1;
        $error("buffer hit one cycle after reset");
    end

endmodule

bind fetch_predictor fetch_predictor_sva sva_i (
    .clk  (clk),
    .rst  (rst),
    .pc   (pc),
    .pred (pred)
);

/* test/fetch_predictor_tb.sv */
module fetch_predictor_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import bp_pkg::*;

    typedef enum logic [1:0] {
        op_query,
        op_update,
        op_reset
    } op_e;

    // One row is what gets driven in a cycle and what pred must show in it.
    typedef struct packed {
        op_e               op;
        logic [addr_w-1:0] pc;
        bp_update_t        upd;
        bp_pred_t          exp;
    } row_t;

    localparam int reset_timeout = 8;                   // cycles allowed to leave reset.

    localparam logic [addr_w-1:0] pc_a   = 32'h0000_1008; // history entry 2, buffer entry 2.
    localparam logic [addr_w-1:0] tgt_a  = 32'h0000_2000;
    localparam logic [addr_w-1:0] pc_b   = 32'h0000_3014; // history entry 5, buffer entry 5.
    localparam logic [addr_w-1:0] tgt_b  = 32'h0000_4000;
    localparam logic [addr_w-1:0] pc_j   = 32'h0000_5020; // buffer entry 8, tag 0x140.
    localparam logic [addr_w-1:0] pc_j2  = 32'h0000_5060; // buffer entry 8, tag 0x141.
    localparam logic [addr_w-1:0] tgt_j  = 32'h0000_6000;
    localparam logic [addr_w-1:0] tgt_j2 = 32'h0000_7000;
    localparam logic [addr_w-1:0] tgt_j3 = 32'h0000_7100;

    logic              clk = 1'b0;
    logic              rst;
    logic [addr_w-1:0] pc;
    bp_update_t        update;
    bp_pred_t          pred;

    row_t rows [$];
    int   cur_row;
    int   value_errors;
    int   timeout_errors;
    int   assert_errors;

    fetch_predictor dut_i (
        .clk    (clk),
        .rst    (rst),
        .pc     (pc),
        .update (update),
        .pred   (pred)
    );

    always #20 clk = ~clk;                                // 40 ns period.

    // ----------------------------------------------------------------------
    // compare tasks
    // ----------------------------------------------------------------------

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            value_errors++;
            $display("ERROR row %0d %s: got %h, expected %h", cur_row, name, got, exp);
        end
    endtask

    task automatic check_addr(input string name, input logic [addr_w-1:0] got,
                              input logic [addr_w-1:0] exp);
        if (got !== exp) begin
            value_errors++;
            $display("ERROR row %0d %s: got %h, expected %h", cur_row, name, got, exp);
        end
    endtask

    // ----------------------------------------------------------------------
    // table building
    // ----------------------------------------------------------------------

    function automatic row_t expect_row(op_e op, logic [addr_w-1:0] a, logic t, logic h,
                                        logic [addr_w-1:0] n);
        row_t r;
        r             = '0;
        r.op          = op;
        r.pc          = a;
        r.exp.taken   = t;
        r.exp.hit     = h;
        r.exp.next_pc = n;
        return r;
    endfunction

    task automatic query_at(input logic [addr_w-1:0] a, input logic t, input logic h,
                            input logic [addr_w-1:0] n);
        rows.push_back(expect_row(op_query, a, t, h, n));
    endtask

    // Updates the branch at a and checks the prediction in that same cycle.
    task automatic train_at(input logic [addr_w-1:0] a, input logic outcome,
                            input br_kind_e kind, input logic [addr_w-1:0] target,
                            input logic t, input logic h, input logic [addr_w-1:0] n);
        row_t r;
        r              = expect_row(op_update, a, t, h, n);
        r.upd.valid    = 1'b1;
        r.upd.pc       = a;
        r.upd.taken    = outcome;
        r.upd.kind     = kind;
        r.upd.target   = target;
        rows.push_back(r);
    endtask

    task automatic pulse_reset();
        rows.push_back(expect_row(op_reset, '0, 1'b0, 1'b0, '0));
    endtask

    task automatic build_table();
        query_at(pc_a, 1'b0, 1'b0, pc_a + 32'd4);         // cleared tables.
        query_at(32'h0000_0000, 1'b0, 1'b0, 32'h0000_0004);
        query_at(32'hffff_fffc, 1'b0, 1'b0, 32'h0000_0000);
        query_at(32'h1234_5678, 1'b0, 1'b0, 32'h1234_567c);

        // Branch a is always taken. The history fills with ones first.
        train_at(pc_a, 1'b1, br_cond, tgt_a, 1'b0, 1'b0, pc_a + 32'd4);
        for (int i = 0; i < 9; i++) begin
            train_at(pc_a, 1'b1, br_cond, tgt_a, 1'b0, 1'b1, pc_a + 32'd4);
        end
        query_at(pc_a, 1'b0, 1'b1, pc_a + 32'd4);         // counter under all ones is strong_nt.
        train_at(pc_a, 1'b1, br_cond, tgt_a, 1'b0, 1'b1, pc_a + 32'd4);
        query_at(pc_a, 1'b0, 1'b1, pc_a + 32'd4);         // weak_nt.
        train_at(pc_a, 1'b1, br_cond, tgt_a, 1'b0, 1'b1, pc_a + 32'd4);
        query_at(pc_a, 1'b1, 1'b1, tgt_a);                // weak_t.
        train_at(pc_a, 1'b1, br_cond, tgt_a, 1'b1, 1'b1, tgt_a);
        train_at(pc_a, 1'b1, br_cond, tgt_a, 1'b1, 1'b1, tgt_a);
        query_at(pc_a, 1'b1, 1'b1, tgt_a);                // held at strong_t.

        // One not-taken outcome, then ten taken ones bring the history back to all ones.
        train_at(pc_a, 1'b0, br_cond, tgt_a, 1'b1, 1'b1, tgt_a);
        query_at(pc_a, 1'b0, 1'b1, pc_a + 32'd4);         // history ends in a zero.
        for (int i = 0; i < 10; i++) begin
            train_at(pc_a, 1'b1, br_cond, tgt_a, 1'b0, 1'b1, pc_a + 32'd4);
        end
        query_at(pc_a, 1'b1, 1'b1, tgt_a);                // weak_t is still taken.
        train_at(pc_a, 1'b0, br_cond, tgt_a, 1'b1, 1'b1, tgt_a);
        for (int i = 0; i < 9; i++) begin
            train_at(pc_a, 1'b1, br_cond, tgt_a, 1'b0, 1'b1, pc_a + 32'd4);
        end
        train_at(pc_a, 1'b1, br_cond, tgt_a, 1'b1, 1'b1, tgt_a); // history 0x1ff is weak_t.
        query_at(pc_a, 1'b0, 1'b1, pc_a + 32'd4);         // two steps down to weak_nt.

        // Branch b alternates, starting taken. Outcome k is taken when k is odd.
        train_at(pc_b, 1'b1, br_cond, tgt_b, 1'b0, 1'b0, pc_b + 32'd4);
        for (int k = 2; k <= 14; k++) begin
            train_at(pc_b, k % 2 == 1, br_cond, tgt_b, 1'b0, 1'b1, pc_b + 32'd4);
        end
        // The counter under history 0x2aa reaches weak_t after outcome 13.
        for (int k = 15; k <= 24; k++) begin
            train_at(pc_b, k % 2 == 1, br_cond, tgt_b, k % 2 == 1, 1'b1,
                     (k % 2 == 1) ? tgt_b : pc_b + 32'd4);
        end
        query_at(pc_b, 1'b1, 1'b1, tgt_b);                // last outcome not taken.
        train_at(pc_b, 1'b1, br_cond, tgt_b, 1'b1, 1'b1, tgt_b);
        query_at(pc_b, 1'b0, 1'b1, pc_b + 32'd4);         // last outcome taken.

        // Jumps and buffer replacement at entry 8.
        train_at(pc_j, 1'b1, br_jump, tgt_j, 1'b0, 1'b0, pc_j + 32'd4);
        query_at(pc_j, 1'b1, 1'b1, tgt_j);
        query_at(pc_j2, 1'b0, 1'b0, pc_j2 + 32'd4);       // same index with another tag.
        train_at(pc_j2, 1'b1, br_jump, tgt_j2, 1'b0, 1'b0, pc_j2 + 32'd4);
        query_at(pc_j2, 1'b1, 1'b1, tgt_j2);
        query_at(pc_j, 1'b0, 1'b0, pc_j + 32'd4);         // older entry was replaced.
        train_at(pc_j2, 1'b1, br_jump, tgt_j3, 1'b1, 1'b1, tgt_j2); // old target this cycle.
        query_at(pc_j2, 1'b1, 1'b1, tgt_j3);

        // Reset in the middle of the run clears all trained state.
        pulse_reset();
        query_at(pc_a, 1'b0, 1'b0, pc_a + 32'd4);
        query_at(pc_b, 1'b0, 1'b0, pc_b + 32'd4);
        query_at(pc_j2, 1'b0, 1'b0, pc_j2 + 32'd4);
        // Branch a learns again from a zero history and strong_nt counters.
        train_at(pc_a, 1'b1, br_cond, tgt_a, 1'b0, 1'b0, pc_a + 32'd4);
        train_at(pc_a, 1'b1, br_cond, tgt_a, 1'b0, 1'b1, pc_a + 32'd4);
        query_at(pc_a, 1'b0, 1'b1, pc_a + 32'd4);         // history 3 has a fresh counter.
        train_at(pc_j, 1'b1, br_jump, tgt_j, 1'b0, 1'b0, pc_j + 32'd4);
        query_at(pc_j, 1'b1, 1'b1, tgt_j);
    endtask

    // ----------------------------------------------------------------------
    // driving
    // ----------------------------------------------------------------------

    task automatic release_reset();
        int waited;
        rst = 1'b1;
        repeat (3) @(posedge clk);
        #2;
        rst    = 1'b0;
        waited = 0;
        #1;
        while (!(pred.hit === 1'b0 && pred.next_pc === pc + 32'd4) &&
               waited < reset_timeout) begin
            @(posedge clk);
            #3;
            waited++;
        end
        if (!(pred.hit === 1'b0 && pred.next_pc === pc + 32'd4)) begin
            timeout_errors++;
            $display("timeout: the predictor did not come out of reset in %0d cycles",
                     reset_timeout);
        end
    endtask

    task automatic apply_row(input row_t r);
        @(posedge clk);
        #2;
        rst    = (r.op == op_reset);
        pc     = r.pc;
        update = (r.op == op_update) ? r.upd : bp_update_t'('0);
        if (r.op != op_reset) begin
            #10;                                          // well before the next edge.
            check_bit("pred.taken", pred.taken, r.exp.taken);
            check_bit("pred.hit", pred.hit, r.exp.hit);
            check_addr("pred.next_pc", pred.next_pc, r.exp.next_pc);
        end
    endtask

    initial begin
        value_errors   = 0;
        timeout_errors = 0;
        assert_errors  = 0;
        cur_row        = 0;
        rst            = 1'b1;
        pc             = '0;
        update         = '0;
        build_table();
        release_reset();
        if (timeout_errors == 0) begin
            foreach (rows[i]) begin
                cur_row = i;
                apply_row(rows[i]);
            end
        end
        @(posedge clk);
        #2;
        update = '0;
        repeat (2) @(posedge clk);                        // let the last assertions sample.
        assert_errors = dut_i.sva_i.fail_count;
        $display("errors: %0d value, %0d assertion, %0d timeout",
                 value_errors, assert_errors, timeout_errors);
        if (value_errors + assert_errors + timeout_errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

/* verilog/bp_pkg.sv */
package bp_pkg;

    // ----------------------------------------------------------------------
    // widths and table sizes
    // ----------------------------------------------------------------------

    localparam int addr_w    = 32;                    // fetch and target address width.
    localparam int pc_idx_w  = 5;                     // address bits above bit 1 used as index.
    localparam int hist_w    = 10;                    // local history length per entry.
    localparam int pht_idx_w = hist_w + pc_idx_w;     // history above address index bits.
    localparam int btb_idx_w = 4;                     // buffer index bits above bit 1.

    localparam int hist_size = 2 ** pc_idx_w;         // entries in the history table.
    localparam int pht_size  = 2 ** pht_idx_w;        // 2-bit counters in the pattern table.
    localparam int btb_size  = 2 ** btb_idx_w;        // entries in the target buffer.
    localparam int btb_tag_w = addr_w - btb_idx_w - 2; // tag covers bits 31 down to 6.

    // ----------------------------------------------------------------------
    // encodings
    // ----------------------------------------------------------------------

    // Two-bit saturating counter. The upper bit is the direction guess.
    typedef enum logic [1:0] {
        strong_nt = 2'd0,
        weak_nt   = 2'd1,
        weak_t    = 2'd2,
        strong_t  = 2'd3
    } counter_e;

    typedef enum logic [1:0] {
        br_none = 2'd0,                               // not a branch or not known.
        br_cond = 2'd1,                               // conditional branch.
        br_jump = 2'd2                                // unconditional jump.
    } br_kind_e;

    // ----------------------------------------------------------------------
    // structs
    // ----------------------------------------------------------------------

    // Resolved branch from a later stage. It is valid for one cycle only.
    typedef struct packed {
        logic              valid;
        logic [addr_w-1:0] pc;
        logic              taken;
        br_kind_e          kind;
        logic [addr_w-1:0] target;
    } bp_update_t;

    typedef struct packed {
        logic              hit;                       // valid entry with matching tag.
        br_kind_e          kind;                      // br_none on a miss.
        logic [addr_w-1:0] target;
    } btb_lookup_t;

    typedef struct packed {
        logic              taken;                     // fetch is redirected to the target.
        logic              hit;
        logic [addr_w-1:0] next_pc;
    } bp_pred_t;

endpackage

/* verilog/branch_target_buffer.sv */
module branch_target_buffer (
    input  logic                     clk,
    input  logic                     rst,
    input  logic [bp_pkg::addr_w-1:0] pc,
    input  bp_pkg::bp_update_t       update,
    output bp_pkg::btb_lookup_t      lookup
);
    import bp_pkg::*;

    // ----------------------------------------------------------------------
    // storage
    // ----------------------------------------------------------------------

    logic                 valid_q  [btb_size];        // cleared by reset.
    logic [btb_tag_w-1:0] tag_q    [btb_size];
    br_kind_e             kind_q   [btb_size];
    logic [addr_w-1:0]    target_q [btb_size];

    logic [btb_idx_w-1:0] idx;
    logic [btb_tag_w-1:0] tag;
    logic                 hit;

    logic [btb_idx_w-1:0] u_idx;
    logic [btb_tag_w-1:0] u_tag;
    logic                 write;

    // ----------------------------------------------------------------------
    // lookup
    // ----------------------------------------------------------------------

    assign idx = pc[btb_idx_w+1:2];                   // bits 5 to 2.
    assign tag = pc[addr_w-1:btb_idx_w+2];            // bits 31 to 6.
    assign hit = valid_q[idx] && tag_q[idx] == tag;

    always_comb begin
        lookup.hit    = hit;
        lookup.kind   = hit ? kind_q[idx] : br_none;  // a miss looks like no branch.
        lookup.target = target_q[idx];
    end

    // ----------------------------------------------------------------------
    // update
    // ----------------------------------------------------------------------

    assign u_idx = update.pc[btb_idx_w+1:2];
    assign u_tag = update.pc[addr_w-1:btb_idx_w+2];
    assign write = update.valid && update.kind != br_none; // taken or not, the entry is kept.

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < btb_size; i++) begin
                valid_q[i] <= 1'b0;
            end
        end else if (write) begin
            valid_q[u_idx] <= 1'b1;
        end
    end

    // Payload fields. The newest branch at an index replaces the old one.
    always_ff @(posedge clk) begin
        if (write) begin
            tag_q[u_idx]    <= u_tag;
            kind_q[u_idx]   <= update.kind;
            target_q[u_idx] <= update.target;
        end
    end

endmodule

/* verilog/fetch_predictor.sv */
module fetch_predictor (
    input  logic                      clk,
    input  logic                      rst,
    input  logic [bp_pkg::addr_w-1:0] pc,
    input  bp_pkg::bp_update_t        update,
    output bp_pkg::bp_pred_t          pred
);
    import bp_pkg::*;

    logic        pred_taken;                          // raw direction guess.
    btb_lookup_t lookup;

    // ----------------------------------------------------------------------
    // direction, target and selection
    // ----------------------------------------------------------------------

    local_history_predictor lhp_i (
        .clk        (clk),
        .rst        (rst),
        .pc         (pc),
        .update     (update),
        .pred_taken (pred_taken)
    );

    branch_target_buffer btb_i (
        .clk    (clk),
        .rst    (rst),
        .pc     (pc),
        .update (update),
        .lookup (lookup)
    );

    // All of pc to pred is combinational within the cycle.
    next_pc_select sel_i (
        .pc         (pc),
        .pred_taken (pred_taken),
        .lookup     (lookup),
        .pred       (pred)
    );

endmodule

/* verilog/local_history_predictor.sv */
module local_history_predictor (
    input  logic                     clk,
    input  logic                     rst,
    input  logic [bp_pkg::addr_w-1:0] pc,
    input  bp_pkg::bp_update_t       update,
    output logic                     pred_taken
);
    import bp_pkg::*;

    // ----------------------------------------------------------------------
    // tables
    // ----------------------------------------------------------------------

    logic [hist_w-1:0] history [hist_size];           // per-address local history.
    counter_e          counters [pht_size];           // indexed by {history, address bits}.

    logic [pc_idx_w-1:0]  hist_idx;
    logic [pht_idx_w-1:0] pht_idx;
    counter_e             count;

    logic [pc_idx_w-1:0]  u_hist_idx;
    logic [pht_idx_w-1:0] u_pht_idx;
    counter_e             u_count;
    counter_e             u_count_next;
    logic                 train;

    // Moves a counter one step toward the outcome and holds it at either end.
    function automatic counter_e step_counter(counter_e cur, logic taken);
        counter_e nxt;
        nxt = cur;
        if (taken && cur != strong_t) begin
            nxt = counter_e'(cur + 2'd1);
        end else if (!taken && cur != strong_nt) begin
            nxt = counter_e'(cur - 2'd1);
        end
        return nxt;
    endfunction

    // ----------------------------------------------------------------------
    // lookup
    // ----------------------------------------------------------------------

    assign hist_idx   = pc[pc_idx_w+1:2];             // bits 6 to 2.
    assign pht_idx    = {history[hist_idx], hist_idx};
    assign count      = counters[pht_idx];
    assign pred_taken = count[1];                     // upper bit is the guess.

    // ----------------------------------------------------------------------
    // training
    // ----------------------------------------------------------------------

    assign u_hist_idx   = update.pc[pc_idx_w+1:2];
    assign u_pht_idx    = {history[u_hist_idx], u_hist_idx}; // history before this outcome.
    assign u_count      = counters[u_pht_idx];
    assign u_count_next = step_counter(u_count, update.taken);
    assign train        = update.valid && update.kind == br_cond; // only conditionals train.

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < pht_size; i++) begin
                counters[i] <= strong_nt;
            end
            for (int i = 0; i < hist_size; i++) begin
                history[i] <= '0;
            end
        end else if (train) begin
            counters[u_pht_idx] <= u_count_next;
            history[u_hist_idx] <= {history[u_hist_idx][hist_w-2:0], update.taken};
        end
    end

endmodule

/* verilog/next_pc_select.sv */
module next_pc_select (
    input  logic [bp_pkg::addr_w-1:0] pc,
    input  logic                      pred_taken,
    input  bp_pkg::btb_lookup_t       lookup,
    output bp_pkg::bp_pred_t          pred
);
    import bp_pkg::*;

    logic              is_jump;
    logic              is_cond;
    logic              redirect;
    logic [addr_w-1:0] seq_pc;

    // ----------------------------------------------------------------------
    // redirect decision
    // ----------------------------------------------------------------------

    assign is_jump = lookup.hit && lookup.kind == br_jump; // jumps are always taken.
    assign is_cond = lookup.hit && lookup.kind == br_cond;

    // A guess for an address with no buffer entry has no target to go to.
    assign redirect = is_jump || (is_cond && pred_taken);

    assign seq_pc = pc + addr_w'(4);                  // next sequential fetch.

    // ----------------------------------------------------------------------
    // prediction
    // ----------------------------------------------------------------------

    always_comb begin
        pred.taken   = redirect;
        pred.hit     = lookup.hit;
        pred.next_pc = redirect ? lookup.target : seq_pc;
    end

endmodule

/* vlog.f */
verilog/bp_pkg.sv
verilog/local_history_predictor.sv
verilog/branch_target_buffer.sv
verilog/next_pc_select.sv
verilog/fetch_predictor.sv
test/fetch_predictor_sva.sv
test/fetch_predictor_tb.sv
